/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// major opcodes of the base integer set that this core runs
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} fmt_e;

	// the low three bits follow funct3 so OP and OP_IMM map almost directly
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111
	} alu_op_e;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// access width and extension of loads and stores
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	typedef struct packed {
		opcode_e     opcode;
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [3:0]  rd;
		logic [2:0]  funct3;
		logic [31:0] imm;
		alu_op_e     alu_op;
		logic        use_imm;
		logic        reg_wen;
		logic        is_load;
		logic        is_store;
		logic        is_branch;
		logic        is_jump;
		logic        illegal;
	} decoded_t;

endpackage

`default_nettype wire

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// one request on the shared port, addr is the byte address of the access
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        write;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        err;
	} mem_rsp_t;

	// rd and wdata read as zero whenever wen is low
	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  rd;
		logic [31:0] wdata;
		logic        wen;
		logic        trap;
		logic        is_store;
	} retire_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
	import isa_pkg::*, mem_pkg::*;
#(
	parameter logic [31:0] RESET_PC = 32'h3000_0000
) (
	input  logic        clock,
	input  logic        rst_n,
	output logic        req_valid,
	input  logic        req_ready,
	output mem_req_t    req,
	input  logic        rsp_valid,
	input  mem_rsp_t    rsp,
	input  decoded_t    dec,
	input  logic [31:0] next_pc,
	input  logic [31:0] mem_addr,
	input  logic [31:0] store_wdata,
	input  logic [3:0]  store_wstrb,
	output logic [31:0] inst,
	output logic [31:0] pc,
	output logic        commit,
	output logic        trap,
	output logic [31:0] load_data,
	output logic [1:0]  load_offset
);
	typedef enum logic [2:0] {
		FETCH,
		WAIT_INST,
		EXEC,
		MEM,
		WAIT_DATA,
		COMMIT
	} state_e;

	state_e      state;
	state_e      state_d;
	logic [31:0] next_pc_q;
	mem_req_t    data_req;

	always_comb begin
		state_d = state;
		case (state)
			FETCH:     if (req_valid && req_ready) state_d = WAIT_INST;
			WAIT_INST: if (rsp_valid) state_d = rsp.err ? COMMIT : EXEC;
			EXEC: begin
				if (!dec.illegal && (dec.is_load || dec.is_store))
					state_d = MEM;
				else
					state_d = COMMIT;
			end
			MEM:       if (req_valid && req_ready) state_d = WAIT_DATA;
			WAIT_DATA: if (rsp_valid) state_d = COMMIT;
			default:   state_d = FETCH;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= FETCH;
			req_valid <= 1'b0;
			commit    <= 1'b0;
			trap      <= 1'b0;
			pc        <= RESET_PC;
		end else begin
			state <= state_d;
			// the request rises on entry into FETCH or MEM and drops on transfer
			req_valid <= (state_d == FETCH) || (state_d == MEM);
			commit    <= (state_d == COMMIT);
			case (state)
				WAIT_INST: if (rsp_valid) trap <= rsp.err;
				EXEC:      trap <= dec.illegal;
				WAIT_DATA: if (rsp_valid) trap <= rsp.err;
				COMMIT: begin
					trap <= 1'b0;
					pc   <= trap ? RESET_PC : next_pc_q;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == WAIT_INST && rsp_valid)
			inst <= rsp.rdata;
		if (state == EXEC) begin
			next_pc_q      <= next_pc;
			data_req.addr  <= mem_addr;
			data_req.wdata <= dec.is_store ? store_wdata : 32'd0;
			data_req.wstrb <= dec.is_store ? store_wstrb : 4'd0;
			data_req.write <= dec.is_store;
		end
		if (state == WAIT_DATA && rsp_valid)
			load_data <= rsp.rdata;
	end

	always_comb begin
		if (state == MEM) begin
			req = data_req;
		end else begin
			req.addr  = pc;
			req.wdata = 32'd0;
			req.wstrb = 4'd0;
			req.write = 1'b0;
		end
	end

	assign load_offset = data_req.addr[1:0];

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit
	import isa_pkg::*;
(
	input  logic [31:0] inst,
	output decoded_t    dec
);
	fmt_e       fmt;
	logic [2:0] funct3;
	logic       uses_rs1;
	logic       uses_rs2;
	logic       uses_rd;
	logic       bad_reg;

	assign funct3 = inst[14:12];

	always_comb begin
		dec        = '0;
		dec.opcode = opcode_e'(inst[6:0]);
		dec.rs1    = inst[18:15];
		dec.rs2    = inst[23:20];
		dec.rd     = inst[10:7];
		dec.funct3 = funct3;
		dec.alu_op = ALU_ADD;
		fmt        = FMT_R;
		uses_rs1   = 1'b0;
		uses_rs2   = 1'b0;
		uses_rd    = 1'b0;
		case (dec.opcode)
			OP: begin
				uses_rs1    = 1'b1;
				uses_rs2    = 1'b1;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				// bit 30 picks sub and sra, it has no meaning for the other funct3 values
				dec.alu_op  = alu_op_e'({inst[30] & (funct3 == 3'b000 || funct3 == 3'b101),
					funct3});
			end
			OP_IMM: begin
				fmt         = FMT_I;
				uses_rs1    = 1'b1;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.use_imm = 1'b1;
				dec.alu_op  = alu_op_e'({inst[30] & (funct3 == 3'b101), funct3});
			end
			LUI: begin
				fmt         = FMT_U;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.use_imm = 1'b1;
				dec.alu_op  = ALU_PASS_B;
			end
			AUIPC: begin
				fmt         = FMT_U;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.use_imm = 1'b1;
			end
			JAL: begin
				fmt         = FMT_J;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.is_jump = 1'b1;
			end
			JALR: begin
				fmt         = FMT_I;
				uses_rs1    = 1'b1;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.use_imm = 1'b1;
				dec.is_jump = 1'b1;
			end
			BRANCH: begin
				fmt           = FMT_B;
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
				dec.is_branch = 1'b1;
			end
			LOAD: begin
				fmt         = FMT_I;
				uses_rs1    = 1'b1;
				uses_rd     = 1'b1;
				dec.reg_wen = 1'b1;
				dec.use_imm = 1'b1;
				dec.is_load = 1'b1;
			end
			STORE: begin
				fmt          = FMT_S;
				uses_rs1     = 1'b1;
				uses_rs2     = 1'b1;
				dec.use_imm  = 1'b1;
				dec.is_store = 1'b1;
			end
			default: dec.illegal = 1'b1;
		endcase
		case (fmt)
			FMT_I:   dec.imm = {{20{inst[31]}}, inst[31:20]};
			FMT_S:   dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			FMT_B:   dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			FMT_U:   dec.imm = {inst[31:12], 12'd0};
			FMT_J:   dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default: dec.imm = 32'd0;
		endcase
		// only fields that the format really carries are checked against the 16 registers
		bad_reg     = (uses_rs1 & inst[19]) | (uses_rs2 & inst[24]) | (uses_rd & inst[11]);
		dec.illegal = dec.illegal | bad_reg;
	end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit
	import isa_pkg::*;
(
	input  decoded_t    dec,
	input  logic [31:0] pc,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	output logic [31:0] alu_result,
	output logic [31:0] next_pc,
	output logic [31:0] mem_addr,
	output logic [31:0] store_wdata,
	output logic [3:0]  store_wstrb
);
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] pc_plus4;
	logic [31:0] pc_target;
	logic        branch_taken;
	logic        take_jump;

	assign op_a      = (dec.opcode == AUIPC) ? pc : src1;
	assign op_b      = dec.use_imm ? dec.imm : src2;
	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + dec.imm;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << op_b[4:0];
			ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> op_b[4:0];
			ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = op_a + op_b;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			F3_BEQ:  branch_taken = (src1 == src2);
			F3_BNE:  branch_taken = (src1 != src2);
			F3_BLT:  branch_taken = $signed(src1) < $signed(src2);
			F3_BGE:  branch_taken = $signed(src1) >= $signed(src2);
			F3_BLTU: branch_taken = src1 < src2;
			F3_BGEU: branch_taken = src1 >= src2;
			default: branch_taken = 1'b0;
		endcase
	end

	assign take_jump  = dec.is_jump | (dec.is_branch & branch_taken);
	// jumps write the link address, everything else the ALU value
	assign alu_result = dec.is_jump ? pc_plus4 : alu_out;
	assign mem_addr   = alu_out;

	always_comb begin
		if (!take_jump)
			next_pc = pc_plus4;
		else if (dec.opcode == JALR)
			next_pc = {alu_out[31:1], 1'b0};
		else
			next_pc = pc_target;
	end

	// store data is replicated over the lanes and the strobe picks the ones written
	always_comb begin
		case (dec.funct3)
			F3_B: begin
				store_wdata = {4{src2[7:0]}};
				store_wstrb = 4'b0001 << alu_out[1:0];
			end
			F3_H: begin
				store_wdata = {2{src2[15:0]}};
				store_wstrb = alu_out[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				store_wdata = src2;
				store_wstrb = 4'b1111;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/result_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module result_unit
	import isa_pkg::*, mem_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  logic        commit,
	input  logic        trap,
	input  decoded_t    dec,
	input  logic [31:0] pc,
	input  logic [31:0] alu_result,
	input  logic [31:0] load_data,
	input  logic [1:0]  load_offset,
	input  logic        store_flag,
	output logic        rf_wen,
	output logic [3:0]  rf_waddr,
	output logic [31:0] rf_wdata,
	output logic        retire,
	output retire_t     retire_info
);
	logic [31:0] alu_q;
	logic [31:0] load_shifted;
	logic [15:0] load_half;
	logic [31:0] load_value;

	// operands hold still from EXEC until commit, so sampling every cycle keeps the EXEC value
	always_ff @(posedge clock) begin
		if (!rst_n)
			alu_q <= 32'd0;
		else
			alu_q <= alu_result;
	end

	assign load_shifted = load_data >> {load_offset, 3'b000};
	assign load_half    = load_offset[1] ? load_data[31:16] : load_data[15:0];

	always_comb begin
		case (dec.funct3)
			F3_B:    load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
			F3_H:    load_value = {{16{load_half[15]}}, load_half};
			F3_W:    load_value = load_data;
			F3_BU:   load_value = {24'd0, load_shifted[7:0]};
			F3_HU:   load_value = {16'd0, load_half};
			default: load_value = load_data;
		endcase
	end

	assign rf_wen   = commit & dec.reg_wen & ~trap & (dec.rd != 4'd0);
	assign rf_waddr = dec.rd;
	assign rf_wdata = dec.is_load ? load_value : alu_q;

	assign retire = commit;

	always_comb begin
		retire_info.pc       = pc;
		retire_info.rd       = rf_wen ? dec.rd : 4'd0;
		retire_info.wdata    = rf_wen ? rf_wdata : 32'd0;
		retire_info.wen      = rf_wen;
		retire_info.trap     = trap;
		retire_info.is_store = store_flag & ~trap;
	end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file #(
	parameter int NUM_REGS = 16,
	localparam int ADDR_W = $clog2(NUM_REGS)
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic [ADDR_W-1:0] raddr1,
	input  logic [ADDR_W-1:0] raddr2,
	input  logic              wen,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [31:0]       wdata,
	output logic [31:0]       rdata1,
	output logic [31:0]       rdata2
);
	// register 0 has no storage
	logic [31:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= 32'd0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

/* rtl/rv32e_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv32e_core
	import isa_pkg::*, mem_pkg::*;
#(
	parameter logic [31:0] RESET_PC = 32'h3000_0000,
	parameter int          NUM_REGS = 16
) (
	input  logic     clock,
	input  logic     rst_n,
	output logic     req_valid,
	input  logic     req_ready,
	output mem_req_t req,
	input  logic     rsp_valid,
	input  mem_rsp_t rsp,
	output logic     retire,
	output retire_t  retire_info
);
	logic [31:0] inst;
	logic [31:0] pc;
	decoded_t    dec;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic [31:0] next_pc;
	logic [31:0] mem_addr;
	logic [31:0] store_wdata;
	logic [3:0]  store_wstrb;
	logic        commit;
	logic        trap;
	logic [31:0] load_data;
	logic [1:0]  load_offset;
	logic        rf_wen;
	logic [3:0]  rf_waddr;
	logic [31:0] rf_wdata;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.dec(dec),
		.next_pc(next_pc),
		.mem_addr(mem_addr),
		.store_wdata(store_wdata),
		.store_wstrb(store_wstrb),
		.inst(inst),
		.pc(pc),
		.commit(commit),
		.trap(trap),
		.load_data(load_data),
		.load_offset(load_offset)
	);

	decode_unit u_decode (
		.inst(inst),
		.dec(dec)
	);

	execute_unit u_execute (
		.dec(dec),
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.alu_result(alu_result),
		.next_pc(next_pc),
		.mem_addr(mem_addr),
		.store_wdata(store_wdata),
		.store_wstrb(store_wstrb)
	);

	result_unit u_result (
		.clock(clock),
		.rst_n(rst_n),
		.commit(commit),
		.trap(trap),
		.dec(dec),
		.pc(pc),
		.alu_result(alu_result),
		.load_data(load_data),
		.load_offset(load_offset),
		.store_flag(dec.is_store),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.retire(retire),
		.retire_info(retire_info)
	);

	register_file #(
		.NUM_REGS(NUM_REGS)
	) u_regs (
		.clock(clock),
		.rst_n(rst_n),
		.raddr1(dec.rs1),
		.raddr2(dec.rs2),
		.wen(rf_wen),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.rdata1(src1),
		.rdata2(src2)
	);

endmodule

`default_nettype wire

/* sim/core_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module core_properties
	import mem_pkg::*;
(
	input wire logic     clock,
	input wire logic     rst_n,
	input wire logic     req_valid,
	input wire logic     req_ready,
	input wire mem_req_t req,
	input wire logic     retire
);
	// a request waiting for ready keeps its valid and its payload
	a_req_stable: assert property (@(posedge clock) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(req))
		else $error("request changed before its transfer");

	a_reset_quiet: assert property (@(posedge clock)
		!rst_n |=> !req_valid && !retire)
		else $error("request or retire active after a reset edge");

	a_retire_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		retire |=> !retire)
		else $error("retire high on two consecutive cycles");

endmodule

bind rv32e_core core_properties u_props (
	.clock(clock),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req(req),
	.retire(retire)
);

`default_nettype wire

/* sim/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb
	import mem_pkg::*;
;
	localparam logic [31:0] RESET_PC = 32'h3000_0000;

	logic     clock;
	logic     rst_n;
	logic     req_valid;
	logic     req_ready;
	mem_req_t req;
	logic     rsp_valid;
	mem_rsp_t rsp;
	logic     retire;
	retire_t  retire_info;

	// memory seen by the DUT and the shadow copy kept by the reference model
	logic [31:0] mem [0:127];
	logic [31:0] smem [0:127];
	logic [31:0] sregs [0:31];
	logic [31:0] s_pc;
	logic [31:0] prog [$];

	logic [31:0] lfsr;
	logic        pend;
	mem_req_t    preq;
	logic [1:0]  wait_cnt;
	int          cycle;
	int          last_rsp_cycle;
	int          limit;
	int          mismatches;
	int          other_errors;
	int          retired;
	logic [31:0] end_pc;

	rv32e_core #(
		.RESET_PC(RESET_PC),
		.NUM_REGS(16)
	) DUT (
		.clock(clock),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.retire(retire),
		.retire_info(retire_info)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic err_window(input logic [31:0] addr);
		return addr[31:28] == 4'h4;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] op);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input int rs1, input int rs2,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
			input logic [6:0] op);
		return {imm, rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// steps the shadow state over the instruction at s_pc and gives its retire report
	function automatic void ref_step(output retire_t e, output logic [31:0] st_addr,
			output logic mem_op);
		logic [31:0] inst;
		logic [31:0] ii;
		logic [31:0] is;
		logic [31:0] ib;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] npc;
		logic [31:0] addr;
		logic [31:0] sh;
		logic [31:0] ba;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic        wr;
		logic        trap;
		logic        st;
		logic        take;
		int          n;
		inst = smem[s_pc[8:2]];
		f3 = inst[14:12];
		rd = inst[11:7];
		ii = {{20{inst[31]}}, inst[31:20]};
		is = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		ib = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		a = sregs[inst[19:15]];
		b = sregs[inst[24:20]];
		npc = s_pc + 32'd4;
		val = 32'd0;
		addr = 32'd0;
		wr = 1'b0;
		trap = 1'b0;
		st = 1'b0;
		mem_op = 1'b0;
		case (inst[6:0])
			7'h33: begin
				wr = 1'b1;
				val = alu(f3, inst[30], a, b);
			end
			7'h13: begin
				wr = 1'b1;
				val = alu(f3, inst[30] && f3 == 3'd5, a, ii);
			end
			7'h37: begin
				wr = 1'b1;
				val = {inst[31:12], 12'd0};
			end
			7'h17: begin
				wr = 1'b1;
				val = s_pc + {inst[31:12], 12'd0};
			end
			7'h6f: begin
				wr = 1'b1;
				val = s_pc + 32'd4;
				npc = s_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			7'h67: begin
				wr = 1'b1;
				val = s_pc + 32'd4;
				npc = (a + ii) & ~32'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take)
					npc = s_pc + ib;
			end
			7'h03: begin
				wr = 1'b1;
				mem_op = 1'b1;
				addr = a + ii;
				sh = smem[addr[8:2]] >> (8 * addr[1:0]);
				trap = err_window(addr);
				case (f3)
					3'd0: val = {{24{sh[7]}}, sh[7:0]};
					3'd1: val = {{16{sh[15]}}, sh[15:0]};
					3'd4: val = {24'd0, sh[7:0]};
					3'd5: val = {16'd0, sh[15:0]};
					default: val = sh;
				endcase
			end
			7'h23: begin
				st = 1'b1;
				mem_op = 1'b1;
				addr = a + is;
				n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
				for (int k = 0; k < n; k++) begin
					ba = addr + k;
					smem[ba[8:2]][8 * ba[1:0] +: 8] = b[8 * k +: 8];
				end
			end
			default: trap = 1'b1;
		endcase
		if (trap) begin
			npc = RESET_PC;
			wr = 1'b0;
		end
		e.pc = s_pc;
		e.wen = wr && rd != 5'd0;
		e.rd = e.wen ? rd[3:0] : 4'd0;
		e.wdata = e.wen ? val : 32'd0;
		e.trap = trap;
		e.is_store = st && !trap;
		if (e.wen)
			sregs[rd] = val;
		s_pc = npc;
		st_addr = addr;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic put(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic finish_run();
		$display("retired %0d, mismatches %0d, other errors %0d", retired, mismatches,
			other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	task automatic timeout_abort();
		other_errors++;
		$display("timeout: the program did not reach its end loop within %0d cycles", limit);
		finish_run();
	endtask

	initial begin
		int a_idx;
		int b_idx;
		logic [31:0] addr;
		rst_n = 1'b0;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp = '0;
		pend = 1'b0;
		preq = '0;
		wait_cnt = 2'd0;
		lfsr = 32'h9f1;
		cycle = 0;
		last_rsp_cycle = 0;
		mismatches = 0;
		other_errors = 0;
		retired = 0;
		for (int i = 0; i < 32; i++)
			sregs[i] = 32'd0;
		// x15 counts passes through the header, it survives the restarts
		put(32'd0);
		put(enc_i(1, 0, 3'd0, 14, 7'h13));
		put(32'd0);
		put(enc_j(0, 0));
		a_idx = prog.size();
		put(enc_i(-7, 0, 3'd0, 1, 7'h13));
		put(enc_i(5, 0, 3'd0, 2, 7'h13));
		for (int f = 0; f < 8; f++)
			put(enc_r(7'h00, 2, 1, f[2:0], 3 + f, 7'h33));
		put(enc_r(7'h20, 2, 1, 3'd0, 11, 7'h33));
		put(enc_r(7'h20, 2, 1, 3'd5, 12, 7'h33));
		put(enc_i(-8, 1, 3'd2, 13, 7'h13));
		put(enc_i(-1, 2, 3'd3, 13, 7'h13));
		put(enc_i('h55, 1, 3'd4, 13, 7'h13));
		put(enc_i('h0f0, 1, 3'd6, 13, 7'h13));
		put(enc_i('h7f3, 1, 3'd7, 13, 7'h13));
		put(enc_i(4, 1, 3'd1, 13, 7'h13));
		put(enc_i(28, 1, 3'd5, 13, 7'h13));
		put(enc_i('h402, 1, 3'd5, 13, 7'h13));
		put(enc_i(1, 1, 3'd0, 0, 7'h13));
		put(enc_u(20'h12345, 1, 7'h37));
		put(enc_u(20'h00010, 2, 7'h17));
		put(enc_j(8, 3));
		put(enc_i(99, 0, 3'd0, 4, 7'h13));
		put(enc_u(20'h0, 6, 7'h17));
		put(enc_i(12, 6, 3'd0, 5, 7'h67));
		put(enc_i(98, 0, 3'd0, 4, 7'h13));
		put(enc_i(-1, 0, 3'd0, 1, 7'h13));
		put(enc_i(1, 0, 3'd0, 2, 7'h13));
		// each branch skips one filler when taken
		for (int k = 0; k < 8; k++) begin
			if (k != 2 && k != 3) begin
				put(enc_b(8, 1, 2, k[2:0]));
				put(enc_i(k + 1, 0, 3'd0, 4, 7'h13));
			end
		end
		// the data region sits well past the end of the program
		put(enc_u(20'h30000, 8, 7'h37));
		put(enc_i('h180, 8, 3'd0, 8, 7'h13));
		put(enc_u(20'h8badf, 9, 7'h37));
		put(enc_i(13, 9, 3'd0, 9, 7'h13));
		put(enc_s(0, 9, 8, 3'd2));
		for (int k = 4; k < 8; k++)
			put(enc_s(k, 9, 8, 3'd0));
		put(enc_s(8, 9, 8, 3'd1));
		put(enc_s(14, 9, 8, 3'd1));
		put(enc_i(4, 8, 3'd0, 10, 7'h03));
		put(enc_i(5, 8, 3'd4, 11, 7'h03));
		put(enc_i(2, 8, 3'd0, 11, 7'h03));
		put(enc_i(14, 8, 3'd1, 12, 7'h03));
		put(enc_i(8, 8, 3'd5, 12, 7'h03));
		put(enc_i(2, 8, 3'd1, 10, 7'h03));
		put(enc_i(0, 8, 3'd2, 13, 7'h03));
		put(enc_i(3, 8, 3'd4, 10, 7'h03));
		put(enc_u(20'h40000, 6, 7'h37));
		put(enc_i(1, 0, 3'd0, 15, 7'h13));
		put(enc_i(0, 6, 3'd2, 7, 7'h03));
		b_idx = prog.size();
		put(enc_i(2, 0, 3'd0, 15, 7'h13));
		put(32'h0000_000b);
		prog[0] = enc_b(a_idx * 4, 15, 0, 3'd0);
		prog[2] = enc_b((b_idx - 2) * 4, 15, 14, 3'd0);
		end_pc = RESET_PC + 32'd12;
		for (int i = 0; i < 128; i++) begin
			addr = RESET_PC + 4 * i;
			mem[i] = (i < prog.size()) ? prog[i] : {addr[15:0] ^ addr[31:16], ~addr[15:0]};
			smem[i] = mem[i];
		end
		s_pc = RESET_PC;
		// the header runs three times, at the start and after each restart
		limit = 60 * (prog.size() + 8);
		repeat (2) @(posedge clock);
		#2;
		rst_n = 1'b1;
	end

	// memory model with random ready and response delay
	always @(posedge clock) begin
		if (rst_n && req_valid && req_ready) begin
			pend = 1'b1;
			preq = req;
			wait_cnt = {lfsr_bit(), lfsr_bit()};
		end
		#2;
		rsp_valid = 1'b0;
		rsp = '0;
		if (pend) begin
			if (wait_cnt == 2'd0) begin
				pend = 1'b0;
				rsp_valid = 1'b1;
				if (err_window(preq.addr)) begin
					rsp.err = 1'b1;
				end else if (preq.write) begin
					for (int k = 0; k < 4; k++)
						if (preq.wstrb[k])
							mem[preq.addr[8:2]][8 * k +: 8] = preq.wdata[8 * k +: 8];
				end else begin
					rsp.rdata = mem[preq.addr[8:2]];
				end
			end else begin
				wait_cnt = wait_cnt - 2'd1;
			end
		end
		req_ready = lfsr_bit();
	end

	always @(posedge clock) begin
		retire_t     exp;
		logic [31:0] st_addr;
		logic        mem_op;
		logic        done;
		cycle++;
		done = 1'b0;
		if (rst_n && retire) begin
			ref_step(exp, st_addr, mem_op);
			check("retire_info.pc", retire_info.pc, exp.pc);
			check("retire_info.rd", {28'd0, retire_info.rd}, {28'd0, exp.rd});
			check("retire_info.wdata", retire_info.wdata, exp.wdata);
			check("retire_info.wen", {31'd0, retire_info.wen}, {31'd0, exp.wen});
			check("retire_info.trap", {31'd0, retire_info.trap}, {31'd0, exp.trap});
			check("retire_info.is_store", {31'd0, retire_info.is_store},
				{31'd0, exp.is_store});
			check("retire latency", cycle - last_rsp_cycle, mem_op ? 1 : 2);
			if (exp.is_store)
				check("memory word", mem[st_addr[8:2]], smem[st_addr[8:2]]);
			retired++;
			done = (exp.pc == end_pc);
		end
		if (rsp_valid)
			last_rsp_cycle = cycle;
		if (done)
			finish_run();
		else if (cycle > limit)
			timeout_abort();
	end

endmodule

`default_nettype wire

/* all.f */
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/register_file.sv
rtl/rv32e_core.sv
sim/core_properties.sv
sim/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, the exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module core_tb -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -Fx '>>> PASS' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
